//--- hw/core_pkg.sv
package core_pkg;

    // --------------------
    // widths and constants
    // --------------------
    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam word_t reset_vector = 32'h0000_0000;

    // --------------------
    // encodings
    // --------------------
    // major opcodes kept by this core, anything else is illegal
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        // lui only
        alu_pass_b
    } alu_op_e;

    typedef enum logic {
        a_sel_rs1,
        a_sel_pc
    } a_sel_e;

    typedef enum logic {
        b_sel_rs2,
        b_sel_imm
    } b_sel_e;

    // --------------------
    // pipeline structs
    // --------------------
    typedef struct packed {
        alu_op_e   alu_op;
        a_sel_e    a_sel;
        b_sel_e    b_sel;
        word_t     imm;
        reg_addr_t rd;
        logic      rf_we;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        // branch kind
        logic [2:0] funct3;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        decoded_t  ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_data;
        word_t     rs2_data;
    } dec_exe_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;
        word_t     data;
        logic      we;
    } retire_t;

endpackage

//--- hw/fetch_unit.sv
module fetch_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  redirect_t redirect_i,
    input  word_t     inst_i,
    output word_t     pc_o,
    output fetch_t    fetch_o
);

    word_t  pc_q;
    word_t  pc_next;
    fetch_t fetch_d;
    fetch_t fetch_q;

    // --------------------
    // program counter
    // --------------------
    // redirect target wins over sequential fetch
    assign pc_next = redirect_i.valid ? redirect_i.target : pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= reset_vector;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // --------------------
    // fetch/decode register
    // --------------------
    // the word fetched while execute redirects is on the wrong path
    assign fetch_d.valid = !redirect_i.valid;
    assign fetch_d.pc    = pc_q;
    assign fetch_d.inst  = inst_i;

    always_ff @(posedge clk) begin
        fetch_q <= fetch_d;
        if (rst) begin
            fetch_q.valid <= 1'b0;
        end
    end

    assign fetch_o = fetch_q;

endmodule

//--- hw/decoder.sv
module decoder import core_pkg::*; (
    input  word_t     inst_i,
    output decoded_t  decoded_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output logic      illegal_o
);

    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    decoded_t   dec;
    logic       illegal;

    // shared by register and immediate ALU forms
    function automatic alu_op_e alu_op_sel(input logic [2:0] fn3, input logic alt);
        case (fn3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign f3 = inst_i[14:12];
    assign f7 = inst_i[31:25];

    // immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
                    1'b0};

    always_comb begin
        dec.alu_op    = alu_add;
        dec.a_sel     = a_sel_rs1;
        dec.b_sel     = b_sel_imm;
        dec.imm       = '0;
        dec.rd        = inst_i[11:7];
        dec.rf_we     = 1'b0;
        dec.is_branch = 1'b0;
        dec.is_jal    = 1'b0;
        dec.is_jalr   = 1'b0;
        dec.funct3    = f3;
        illegal       = 1'b0;

        case (opcode_e'(inst_i[6:0]))
            opc_op: begin
                dec.alu_op = alu_op_sel(f3, f7[5]);
                dec.b_sel  = b_sel_rs2;
                dec.rf_we  = 1'b1;
                illegal = !((f7 == 7'h00) ||
                            ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101))));
            end
            opc_op_imm: begin
                // bit 30 is immediate data except for the right shifts
                dec.alu_op = alu_op_sel(f3, (f3 == 3'b101) && inst_i[30]);
                dec.imm    = imm_i;
                dec.rf_we  = 1'b1;
                illegal = ((f3 == 3'b001) && (f7 != 7'h00)) ||
                          ((f3 == 3'b101) && (f7 != 7'h00) && (f7 != 7'h20));
            end
            opc_lui: begin
                dec.alu_op = alu_pass_b;
                dec.imm    = imm_u;
                dec.rf_we  = 1'b1;
            end
            opc_auipc: begin
                dec.a_sel = a_sel_pc;
                dec.imm   = imm_u;
                dec.rf_we = 1'b1;
            end
            // the ALU forms the target of every control transfer
            opc_jal: begin
                dec.a_sel  = a_sel_pc;
                dec.imm    = imm_j;
                dec.rf_we  = 1'b1;
                dec.is_jal = 1'b1;
            end
            opc_jalr: begin
                dec.imm     = imm_i;
                dec.rf_we   = 1'b1;
                dec.is_jalr = 1'b1;
                illegal     = (f3 != 3'b000);
            end
            opc_branch: begin
                dec.a_sel     = a_sel_pc;
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                illegal       = (f3 == 3'b010) || (f3 == 3'b011);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // no architectural write for these
        if ((dec.rd == '0) || illegal || dec.is_branch) begin
            dec.rf_we = 1'b0;
        end
        if (illegal) begin
            dec.is_branch = 1'b0;
            dec.is_jalr   = 1'b0;
        end
    end

    assign decoded_o = dec;
    assign rs1_o     = inst_i[19:15];
    assign rs2_o     = inst_i[24:20];
    assign illegal_o = illegal;

endmodule

//--- hw/reg_file.sv
module reg_file import core_pkg::*; (
    input  logic       clk,
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    output word_t      rs1_data_o,
    output word_t      rs2_data_o,
    input  reg_write_t wr_i
);

    word_t regs [32];

    // x0 reads zero, a same-cycle write is seen by the read
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_i.we && (wr_i.rd == addr)) begin
            return wr_i.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wr_i.we && (wr_i.rd != '0)) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

endmodule

//--- hw/decode_stage.sv
module decode_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fetch_t     fetch_i,
    input  redirect_t  redirect_i,
    input  reg_write_t wr_i,
    output dec_exe_t   dec_exe_o
);

    decoded_t  decoded;
    reg_addr_t rs1_raw;
    reg_addr_t rs2_raw;
    reg_addr_t rs1_idx;
    reg_addr_t rs2_idx;
    logic      illegal;
    word_t     rs1_data;
    word_t     rs2_data;
    dec_exe_t  dec_exe_d;
    dec_exe_t  dec_exe_q;

    decoder u_decoder (
        .inst_i    (fetch_i.inst),
        .decoded_o (decoded),
        .rs1_o     (rs1_raw),
        .rs2_o     (rs2_raw),
        .illegal_o (illegal)
    );

    // an illegal word has no source fields, keep it off the forward path
    assign rs1_idx = illegal ? '0 : rs1_raw;
    assign rs2_idx = illegal ? '0 : rs2_raw;

    reg_file u_reg_file (
        .clk        (clk),
        .rs1_addr_i (rs1_idx),
        .rs2_addr_i (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (wr_i)
    );

    // --------------------
    // decode/execute register
    // --------------------
    always_comb begin
        dec_exe_d.valid    = fetch_i.valid && !redirect_i.valid;
        dec_exe_d.pc       = fetch_i.pc;
        dec_exe_d.inst     = fetch_i.inst;
        dec_exe_d.ctrl     = decoded;
        dec_exe_d.rs1      = rs1_idx;
        dec_exe_d.rs2      = rs2_idx;
        dec_exe_d.rs1_data = rs1_data;
        dec_exe_d.rs2_data = rs2_data;
    end

    always_ff @(posedge clk) begin
        dec_exe_q <= dec_exe_d;
        if (rst) begin
            dec_exe_q.valid <= 1'b0;
        end
    end

    assign dec_exe_o = dec_exe_q;

endmodule

//--- hw/alu.sv
module alu import core_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            alu_add:    result_o = a_i + b_i;
            alu_sub:    result_o = a_i - b_i;
            alu_sll:    result_o = a_i << shamt;
            alu_slt:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            alu_sltu:   result_o = {31'b0, a_i < b_i};
            alu_xor:    result_o = a_i ^ b_i;
            alu_srl:    result_o = a_i >> shamt;
            alu_sra:    result_o = $unsigned($signed(a_i) >>> shamt);
            alu_or:     result_o = a_i | b_i;
            alu_and:    result_o = a_i & b_i;
            alu_pass_b: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

//--- hw/execute_stage.sv
module execute_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  dec_exe_t   dec_exe_i,
    output redirect_t  redirect_o,
    output reg_write_t wr_o,
    output logic       retire_valid_o,
    output retire_t    retire_o
);

    decoded_t ctrl;
    logic     fwd_rs1;
    logic     fwd_rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_res;
    word_t    link;
    word_t    result;
    logic     cond;
    logic     taken;
    logic     wb_valid_q;
    retire_t  wb_d;
    retire_t  wb_q;

    assign ctrl = dec_exe_i.ctrl;

    // --------------------
    // forwarding from writeback
    // --------------------
    assign fwd_rs1 = wb_valid_q && wb_q.we && (wb_q.rd != '0) && (wb_q.rd == dec_exe_i.rs1);
    assign fwd_rs2 = wb_valid_q && wb_q.we && (wb_q.rd != '0) && (wb_q.rd == dec_exe_i.rs2);

    assign rs1_val = fwd_rs1 ? wb_q.data : dec_exe_i.rs1_data;
    assign rs2_val = fwd_rs2 ? wb_q.data : dec_exe_i.rs2_data;

    assign alu_a = (ctrl.a_sel == a_sel_pc) ? dec_exe_i.pc : rs1_val;
    assign alu_b = (ctrl.b_sel == b_sel_imm) ? ctrl.imm : rs2_val;

    alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_res)
    );

    // branch compare
    always_comb begin
        case (ctrl.funct3)
            3'b000:  cond = (rs1_val == rs2_val);
            3'b001:  cond = (rs1_val != rs2_val);
            3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  cond = (rs1_val < rs2_val);
            3'b111:  cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    // --------------------
    // redirect
    // --------------------
    assign taken = dec_exe_i.valid &&
                   (ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cond));

    assign redirect_o.valid  = taken;
    assign redirect_o.target = ctrl.is_jalr ? {alu_res[31:1], 1'b0} : alu_res;

    // jumps write the link, the ALU is busy with the target
    assign link   = dec_exe_i.pc + 32'd4;
    assign result = (ctrl.is_jal || ctrl.is_jalr) ? link : alu_res;

    // --------------------
    // writeback register
    // --------------------
    always_comb begin
        wb_d.pc   = dec_exe_i.pc;
        wb_d.inst = dec_exe_i.inst;
        wb_d.rd   = ctrl.rd;
        // data reads zero when nothing is written
        wb_d.data = ctrl.rf_we ? result : '0;
        wb_d.we   = ctrl.rf_we;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= dec_exe_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= wb_d;
    end

    assign wr_o.we   = wb_valid_q && wb_q.we;
    assign wr_o.rd   = wb_q.rd;
    assign wr_o.data = wb_q.data;

    assign retire_valid_o = wb_valid_q;
    assign retire_o       = wb_q;

endmodule

//--- hw/rv_core.sv
module rv_core import core_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    output word_t   imem_addr_o,
    input  word_t   imem_data_i,
    output logic    retire_valid_o,
    output retire_t retire_o
);

    fetch_t     fetch;
    dec_exe_t   dec_exe;
    redirect_t  redirect;
    reg_write_t reg_wr;

    // --------------------
    // fetch
    // --------------------
    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .redirect_i (redirect),
        .inst_i     (imem_data_i),
        .pc_o       (imem_addr_o),
        .fetch_o    (fetch)
    );

    // --------------------
    // decode
    // --------------------
    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .fetch_i    (fetch),
        .redirect_i (redirect),
        .wr_i       (reg_wr),
        .dec_exe_o  (dec_exe)
    );

    // --------------------
    // execute and writeback
    // --------------------
    execute_stage u_execute (
        .clk            (clk),
        .rst            (rst),
        .dec_exe_i      (dec_exe),
        .redirect_o     (redirect),
        .wr_o           (reg_wr),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

//--- verif/clk_gen.sv
module clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset held for two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #2 rst_o = 1'b0;
    end

endmodule

//--- verif/core_tb.sv
module core_tb import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int drive_delay     = 2;
    localparam int imem_words      = 256;
    localparam int retire_timeout  = 20;
    localparam int random_programs = 20;
    localparam int random_length   = 60;
    localparam int seed            = 13;
    localparam word_t nop_word     = 32'h0000_0013;
    localparam int code_op_imm     = 'h13;
    localparam int code_lui        = 'h37;
    localparam int code_auipc      = 'h17;
    localparam int code_jalr       = 'h67;

    logic    clk;
    logic    por_rst;
    logic    soft_rst;
    logic    core_rst;
    word_t   imem_addr;
    word_t   imem_data;
    logic    retire_valid;
    retire_t retire;

    word_t   imem [imem_words];
    int      plen;
    word_t   prog_end;
    word_t   ref_regs [32];
    word_t   ref_next_pc;
    retire_t exp_q [$];
    int      exp_idx = 0;
    int      since_rst = 0;
    logic    rst_seen = 1'b0;
    logic    running;

    clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (por_rst)
    );

    assign core_rst = por_rst || soft_rst;

    rv_core dut_i (
        .clk            (clk),
        .rst            (core_rst),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_o       (retire)
    );

    // past the end of the program only nops
    assign imem_data = (imem_addr < prog_end) ? imem[imem_addr[9:2]] : nop_word;

    // --------------------
    // failure reporting
    // --------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at time %0t: %s got %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    // --------------------
    // instruction encoders
    // --------------------
    function automatic word_t r_type(input int f7, input int rs2, input int rs1, input int f3,
                                     input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(input int opc, input int rd, input int f3, input int rs1,
                                     input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t u_type(input int opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t b_type(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic word_t j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                      input word_t b);
        word_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // one architectural step, updates ref_regs and ref_next_pc
    function automatic retire_t ref_step(input word_t pc, input word_t inst);
        retire_t    r;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      value;
        logic       legal;
        logic       writes;
        f3 = inst[14:12];
        f7 = inst[31:25];
        a = ref_regs[inst[19:15]];
        b = ref_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        value = '0;
        legal = 1'b1;
        writes = 1'b1;
        ref_next_pc = pc + 32'd4;
        case (inst[6:0])
            7'h33: begin
                legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
                value = alu_ref(f3, f7[5], a, b);
            end
            7'h13: begin
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                value = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm_i);
            end
            7'h37: value = {inst[31:12], 12'b0};
            7'h17: value = pc + {inst[31:12], 12'b0};
            7'h6f: begin
                value = pc + 32'd4;
                ref_next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
            end
            7'h67: begin
                legal = (f3 == 3'd0);
                value = pc + 32'd4;
                ref_next_pc = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                legal = (f3 != 3'd2) && (f3 != 3'd3);
                writes = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    ref_next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                end
            end
            default: legal = 1'b0;
        endcase
        // illegal words fall through as no-ops
        if (!legal) begin
            ref_next_pc = pc + 32'd4;
        end
        r.pc   = pc;
        r.inst = inst;
        r.rd   = inst[11:7];
        r.we   = legal && writes && (inst[11:7] != 5'd0);
        r.data = r.we ? value : '0;
        if (r.we) begin
            ref_regs[inst[11:7]] = value;
        end
        return r;
    endfunction

    task automatic build_expected();
        word_t pc;
        exp_q.delete();
        pc = reset_vector;
        while (pc < prog_end) begin
            exp_q.push_back(ref_step(pc, imem[pc[9:2]]));
            pc = ref_next_pc;
        end
    endtask

    // --------------------
    // checker
    // --------------------
    always @(posedge clk) begin
        if (core_rst) begin
            since_rst <= 0;
            rst_seen  <= 1'b1;
        end else begin
            since_rst <= since_rst + 1;
            rst_seen  <= 1'b0;
        end
    end

    task automatic compare_retire(input retire_t got, input retire_t exp);
        check_equal(got.pc, exp.pc, "retire pc");
        check_equal(got.inst, exp.inst, $sformatf("inst at pc %h", exp.pc));
        check_equal(32'(got.we), 32'(exp.we), $sformatf("we at pc %h", exp.pc));
        check_equal(32'(got.rd), 32'(exp.rd), $sformatf("rd at pc %h", exp.pc));
        if (exp.we) begin
            check_equal(got.data, exp.data, $sformatf("data at pc %h", exp.pc));
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (core_rst && rst_seen) begin
            check_equal(32'(retire_valid), 32'd0, "retire strobe during reset");
        end
        if (!running) begin
            exp_idx = 0;
        end else if (retire_valid && (exp_idx < exp_q.size())) begin
            if (exp_idx == 0) begin
                check_equal(since_rst, 32'd3, "cycles from reset to first retire");
            end
            compare_retire(retire, exp_q[exp_idx]);
            exp_idx = exp_idx + 1;
        end
    end

    // --------------------
    // program builders
    // --------------------
    task automatic write_word(input word_t w);
        imem[plen] = w;
        plen = plen + 1;
    endtask

    task automatic init_registers();
        for (int r = 1; r < 32; r++) begin
            write_word(u_type(code_lui, r, $urandom));
            write_word(i_type(code_op_imm, r, 0, r, $urandom));
        end
    endtask

    // wrong-path words that must never retire
    task automatic wrong_path_fill();
        write_word(i_type(code_op_imm, 24, 0, 24, 1));
        write_word(i_type(code_op_imm, 24, 0, 24, 1));
    endtask

    task automatic directed_sequence();
        // x1 negative, x2 small positive
        write_word(u_type(code_lui, 1, 'hfffff));
        write_word(i_type(code_op_imm, 1, 0, 1, -8));
        write_word(i_type(code_op_imm, 2, 0, 0, 3));
        write_word(r_type(0, 2, 1, 0, 3));
        write_word(r_type('h20, 2, 1, 0, 4));
        write_word(r_type(0, 2, 1, 1, 5));
        write_word(r_type(0, 2, 1, 2, 6));
        write_word(r_type(0, 2, 1, 3, 7));
        write_word(r_type(0, 2, 1, 4, 8));
        write_word(r_type(0, 2, 1, 5, 9));
        write_word(r_type('h20, 2, 1, 5, 10));
        write_word(r_type(0, 2, 1, 6, 11));
        write_word(r_type(0, 2, 1, 7, 12));
        write_word(i_type(code_op_imm, 13, 2, 1, 5));
        write_word(i_type(code_op_imm, 14, 3, 1, 5));
        write_word(i_type(code_op_imm, 15, 4, 1, -1));
        write_word(i_type(code_op_imm, 16, 6, 1, 'h0f0));
        write_word(i_type(code_op_imm, 17, 7, 1, -16));
        write_word(i_type(code_op_imm, 18, 1, 1, 4));
        write_word(i_type(code_op_imm, 19, 5, 1, 4));
        write_word(i_type(code_op_imm, 20, 5, 1, 'h404));
        write_word(u_type(code_lui, 21, 'h12345));
        write_word(u_type(code_auipc, 22, 'h00001));
        // dependents two apart, then back to back
        write_word(i_type(code_op_imm, 23, 0, 0, 7));
        write_word(i_type(code_op_imm, 24, 0, 0, 1));
        write_word(r_type(0, 23, 23, 0, 25));
        write_word(r_type(0, 25, 23, 0, 25));
        // x0 stays zero, illegal words write nothing
        write_word(i_type(code_op_imm, 0, 0, 0, 5));
        write_word(r_type(0, 0, 0, 0, 26));
        write_word(32'h0000_0000);
        write_word(32'hffff_ffff);
        write_word(r_type('h01, 2, 1, 0, 27));
        write_word(r_type(0, 0, 0, 0, 27));
        // branches, taken ones skip two words
        write_word(b_type(0, 2, 2, 12));
        wrong_path_fill();
        write_word(b_type(1, 2, 2, 12));
        write_word(b_type(4, 1, 2, 12));
        wrong_path_fill();
        write_word(b_type(6, 1, 2, 12));
        write_word(b_type(5, 2, 1, 12));
        wrong_path_fill();
        write_word(b_type(7, 2, 1, 12));
        // jumps and their link registers
        write_word(j_type(28, 12));
        wrong_path_fill();
        write_word(r_type(0, 0, 28, 0, 29));
        write_word(i_type(code_jalr, 30, 0, 0, plen * 4 + 12));
        wrong_path_fill();
        write_word(r_type(0, 0, 30, 0, 31));
    endtask

    function automatic int pick_reg();
        return $urandom % 8;
    endfunction

    function automatic int branch_f3();
        int k;
        k = $urandom % 6;
        return (k < 2) ? k : k + 2;
    endfunction

    function automatic int alu_imm(input int f3, input int alt);
        if (f3 == 1) begin
            return $urandom % 32;
        end
        if (f3 == 5) begin
            return ((alt == 1) ? 'h400 : 0) + int'($urandom % 32);
        end
        return $urandom;
    endfunction

    // control transfers only go forward, at most to the end
    task automatic random_sequence(input int count);
        int last;
        int kind;
        int f3;
        int alt;
        int lim;
        int fwd;
        last = plen + count;
        while (plen < last) begin
            kind = $urandom % 10;
            f3   = $urandom % 8;
            alt  = $urandom % 2;
            lim  = (last - plen < 4) ? last - plen : 4;
            fwd  = 4 * (1 + int'($urandom % lim));
            case (kind)
                0, 1, 2: write_word(r_type(((f3 == 0 || f3 == 5) && alt == 1) ? 'h20 : 0,
                                           pick_reg(), pick_reg(), f3, pick_reg()));
                3, 4: write_word(i_type(code_op_imm, pick_reg(), f3, pick_reg(),
                                        alu_imm(f3, alt)));
                5: write_word(u_type(code_lui, pick_reg(), $urandom));
                6: write_word(u_type(code_auipc, pick_reg(), $urandom));
                7: write_word(b_type(branch_f3(), pick_reg(), pick_reg(), fwd));
                8: write_word(j_type(pick_reg(), fwd));
                default: write_word(i_type(code_jalr, pick_reg(), 0, 0, plen * 4 + fwd));
            endcase
        end
    endtask

    // --------------------
    // run control
    // --------------------
    task automatic start_program();
        @(posedge clk);
        #drive_delay;
        soft_rst = 1'b1;
        running  = 1'b0;
        plen     = 0;
    endtask

    task automatic wait_for_retires();
        int idle;
        int last;
        idle = 0;
        last = 0;
        while (exp_idx < exp_q.size()) begin
            @(posedge clk);
            if (exp_idx != last) begin
                last = exp_idx;
                idle = 0;
            end else begin
                idle = idle + 1;
                if (idle > retire_timeout) begin
                    stop_with_failure($sformatf(
                        "timeout: no instruction retired for %0d cycles", retire_timeout));
                end
            end
        end
    endtask

    task automatic run_program(input string name);
        prog_end = plen * 4;
        build_expected();
        repeat (2) @(posedge clk);
        #drive_delay;
        soft_rst = 1'b0;
        running  = 1'b1;
        wait_for_retires();
        running = 1'b0;
        $display("%s: %0d instructions retired", name, exp_q.size());
    endtask

    initial begin
        void'($urandom(seed));
        soft_rst = 1'b0;
        running  = 1'b0;
        plen     = 0;
        prog_end = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end

        start_program();
        init_registers();
        directed_sequence();
        run_program("directed");

        for (int p = 0; p < random_programs; p++) begin
            start_program();
            init_registers();
            random_sequence(random_length);
            run_program($sformatf("random program %0d", p));
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- sources.f
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/alu.sv
hw/execute_stage.sv
hw/rv_core.sv
verif/clk_gen.sv
verif/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary \
    --timescale 1ns/100ps \
    --top-module core_tb \
    -Mdir build \
    -o core_tb_sim \
    -f sources.f

./build/core_tb_sim
